/* Bender.yml */
package:
  name: vga_ram

sources:
  - src/vga_ram_pkg.sv
  - src/resync_3.sv
  - src/uart_autobaud.sv
  - src/fb_writer.sv
  - src/ram_2048x2b.sv
  - src/frame_store.sv
  - src/vga_timing.sv
  - src/vga_ram.sv
  - target: test
    files:
      - testbench/tb_vga_ram.sv

/* build.f */
src/vga_ram_pkg.sv
src/resync_3.sv
src/uart_autobaud.sv
src/fb_writer.sv
src/ram_2048x2b.sv
src/frame_store.sv
src/vga_timing.sv
src/vga_ram.sv
testbench/tb_vga_ram.sv

/* src/fb_writer.sv */
`timescale 1ns/10ps

module fb_writer (
   input  logic                                pll_clk,
   input  logic                                i_nrst,
   input  logic                                i_rx_valid,
   input  vga_ram_pkg::rx_byte_u               i_rx_byte,
   output logic                                o_we,
   output logic [vga_ram_pkg::FB_ADDR_W-1:0]   o_waddr,
   output vga_ram_pkg::pix_code_t              o_wpix
);

   logic [vga_ram_pkg::FB_ADDR_W-1:0] addr;

   assign o_we    = i_rx_valid;
   assign o_waddr = addr;
   assign o_wpix  = i_rx_byte.cmd.pix;

   // Step on continue, else back to pixel 0
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         addr <= '0;
      end else if (i_rx_valid) begin
         if (i_rx_byte.cmd.cont) begin
            addr <= addr + 1'b1;
         end else begin
            addr <= '0;
         end
      end
   end

   a_waddr_range: assert property (
      @(posedge pll_clk) disable iff (!i_nrst)
      o_we |-> (!$isunknown(o_waddr) &&
                (o_waddr < vga_ram_pkg::FB_SIZE * vga_ram_pkg::FB_SIZE))
   );

endmodule

/* src/frame_store.sv */
`timescale 1ns/10ps

module frame_store (
   input  logic                                pll_clk,
   input  logic                                i_nrst,
   input  logic                                i_we,
   input  logic [vga_ram_pkg::FB_ADDR_W-1:0]   i_waddr,
   input  vga_ram_pkg::pix_code_t              i_wpix,
   input  logic [vga_ram_pkg::CNT_W-1:0]       i_h_next,
   input  logic [vga_ram_pkg::CNT_W-1:0]       i_v_next,
   output vga_ram_pkg::rgb_t                   o_rgb
);

   logic [vga_ram_pkg::N_BANKS-1:0]                           bank_we;
   logic [vga_ram_pkg::FB_ADDR_W-1:0]                         raddr;
   logic                                                      blank_next;
   logic                                                      blank_q;
   logic [vga_ram_pkg::FB_ADDR_W-vga_ram_pkg::BANK_ADDR_W-1:0] sel_q;
   vga_ram_pkg::pix_code_t                                    rdata [vga_ram_pkg::N_BANKS];
   vga_ram_pkg::pix_code_t                                    pix;

   assign raddr = vga_ram_pkg::FB_ADDR_W'(i_v_next * vga_ram_pkg::FB_SIZE + i_h_next);
   assign blank_next = (i_h_next >= vga_ram_pkg::FB_SIZE) ||
                       (i_v_next >= vga_ram_pkg::FB_SIZE);

   //////////////////////////////////////////////////
   // Banks, upper address bits pick the bank
   for (genvar i = 0; i < vga_ram_pkg::N_BANKS; i++) begin : g_bank
      assign bank_we[i] =
         i_we && (i_waddr[vga_ram_pkg::FB_ADDR_W-1:vga_ram_pkg::BANK_ADDR_W] == i);

      ram_2048x2b ram_i (
         .pll_clk (pll_clk),
         .i_we    (bank_we[i]),
         .i_waddr (i_waddr[vga_ram_pkg::BANK_ADDR_W-1:0]),
         .i_wdata (i_wpix),
         .i_raddr (raddr[vga_ram_pkg::BANK_ADDR_W-1:0]),
         .o_rdata (rdata[i])
      );
   end

   // Line up with RAM read latency
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sel_q   <= '0;
         blank_q <= 1'b1;
      end else begin
         sel_q   <= raddr[vga_ram_pkg::FB_ADDR_W-1:vga_ram_pkg::BANK_ADDR_W];
         blank_q <= blank_next;
      end
   end

   assign pix = rdata[sel_q];

   //////////////////////////////////////////////////
   // Palette
   always_comb begin
      o_rgb = vga_ram_pkg::RGB_BLACK;
      if (!blank_q) begin
         case (pix)
            2'b00:   o_rgb = vga_ram_pkg::RGB_BLACK;
            2'b01:   o_rgb = vga_ram_pkg::RGB_RED;
            2'b10:   o_rgb = vga_ram_pkg::RGB_YELLOW;
            2'b11:   o_rgb = vga_ram_pkg::RGB_GREEN;
            default: o_rgb = vga_ram_pkg::RGB_BLACK;   // Unwritten word
         endcase
      end
   end

   a_one_bank_we: assert property (
      @(posedge pll_clk) disable iff (!i_nrst)
      $onehot0(bank_we)
   );

endmodule

/* src/ram_2048x2b.sv */
`timescale 1ns/10ps

module ram_2048x2b (
   input  logic                                  pll_clk,
   input  logic                                  i_we,
   input  logic [vga_ram_pkg::BANK_ADDR_W-1:0]   i_waddr,
   input  vga_ram_pkg::pix_code_t                i_wdata,
   input  logic [vga_ram_pkg::BANK_ADDR_W-1:0]   i_raddr,
   output vga_ram_pkg::pix_code_t                o_rdata
);

   vga_ram_pkg::pix_code_t mem [2**vga_ram_pkg::BANK_ADDR_W];

   always_ff @(posedge pll_clk) begin
      if (i_we) begin
         mem[i_waddr] <= i_wdata;
      end
      o_rdata <= mem[i_raddr];   // Registered read
   end

endmodule

/* src/resync_3.sv */
`timescale 1ns/10ps

module resync_3 (
   input  logic pll_clk,
   input  logic i_nrst,
   input  logic i_d,
   output logic o_q
);

   logic [2:0] sync;

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync <= 3'b111;   // Idle line level
      end else begin
         sync <= {sync[1:0], i_d};
      end
   end

   assign o_q = sync[2];

endmodule

/* src/uart_autobaud.sv */
`timescale 1ns/10ps

module uart_autobaud (
   input  logic                  pll_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx,
   output logic                  o_rx_valid,
   output vga_ram_pkg::rx_byte_u o_rx_byte
);

   typedef enum logic [2:0] {
      ST_WAIT_CAL,
      ST_CAL,
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } rx_state_t;

   rx_state_t                        state;
   logic [vga_ram_pkg::BAUD_W-1:0]   period;
   logic [vga_ram_pkg::BAUD_W-1:0]   cnt;
   logic [2:0]                       bit_idx;
   logic [7:0]                       shift;
   logic                             tick;
   logic                             cal_done;
   logic                             data_tick;
   logic                             stop_ok;

   assign tick      = (cnt == '0);
   assign cal_done  = (state == ST_CAL) && i_rx;    // Start bit just ended
   assign data_tick = (state == ST_DATA) && tick;
   assign stop_ok   = (state == ST_STOP) && tick && i_rx;

   //////////////////////////////////////////////////
   // Control FSM
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= ST_WAIT_CAL;
         cnt        <= '0;
         bit_idx    <= '0;
         o_rx_valid <= 1'b0;
      end else begin
         o_rx_valid <= 1'b0;
         case (state)
            ST_WAIT_CAL: begin
               if (!i_rx) begin
                  state <= ST_CAL;
                  cnt   <= 'd1;
               end
            end
            ST_CAL: begin
               // Low time of first start bit is one bit period
               if (i_rx) begin
                  state   <= ST_DATA;
                  cnt     <= cnt >> 1;
                  bit_idx <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_IDLE: begin
               if (!i_rx) begin
                  state <= ST_START;
                  cnt   <= period >> 1;   // Aim at mid bit
               end
            end
            ST_START: begin
               if (tick) begin
                  if (!i_rx) begin
                     state   <= ST_DATA;
                     cnt     <= period - 1'b1;
                     bit_idx <= '0;
                  end else begin
                     state <= ST_IDLE;    // Glitch
                  end
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            ST_DATA: begin
               if (tick) begin
                  cnt     <= period - 1'b1;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= ST_STOP;
                  end
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            ST_STOP: begin
               if (tick) begin
                  o_rx_valid <= i_rx;     // Framing error drops the byte
                  state      <= ST_IDLE;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            default: state <= ST_WAIT_CAL;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Data path
   always_ff @(posedge pll_clk) begin
      if (cal_done) begin
         period <= cnt;
      end
      if (data_tick) begin
         shift <= {i_rx, shift[7:1]};     // LSB first
      end
      if (stop_ok) begin
         o_rx_byte.raw <= shift;
      end
   end

   a_valid_pulse: assert property (
      @(posedge pll_clk) disable iff (!i_nrst)
      o_rx_valid |=> !o_rx_valid
   );

endmodule

/* src/vga_ram.sv */
`timescale 1ns/10ps

module vga_ram (
   input  logic       pll_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   output logic       o_hs,
   output logic       o_vs,
   output logic [1:0] o_r,
   output logic [1:0] o_g,
   output logic [1:0] o_b
);

   logic                              rx_s;
   logic                              rx_valid;
   vga_ram_pkg::rx_byte_u             rx_byte;
   logic                              we;
   logic [vga_ram_pkg::FB_ADDR_W-1:0] waddr;
   vga_ram_pkg::pix_code_t            wpix;
   logic [vga_ram_pkg::CNT_W-1:0]     h_next;
   logic [vga_ram_pkg::CNT_W-1:0]     v_next;
   vga_ram_pkg::rgb_t                 fs_rgb;
   vga_ram_pkg::rgb_t                 vga_rgb;

   //////////////////////////////////////////////////
   // Serial in
   resync_3 resync_i (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst),
      .i_d     (i_rx),
      .o_q     (rx_s)
   );

   uart_autobaud uart_i (
      .pll_clk    (pll_clk),
      .i_nrst     (i_nrst),
      .i_rx       (rx_s),
      .o_rx_valid (rx_valid),
      .o_rx_byte  (rx_byte)
   );

   fb_writer writer_i (
      .pll_clk    (pll_clk),
      .i_nrst     (i_nrst),
      .i_rx_valid (rx_valid),
      .i_rx_byte  (rx_byte),
      .o_we       (we),
      .o_waddr    (waddr),
      .o_wpix     (wpix)
   );

   //////////////////////////////////////////////////
   // Display
   frame_store store_i (
      .pll_clk  (pll_clk),
      .i_nrst   (i_nrst),
      .i_we     (we),
      .i_waddr  (waddr),
      .i_wpix   (wpix),
      .i_h_next (h_next),
      .i_v_next (v_next),
      .o_rgb    (fs_rgb)
   );

   vga_timing timing_i (
      .pll_clk  (pll_clk),
      .i_nrst   (i_nrst),
      .i_rgb    (fs_rgb),
      .o_h_next (h_next),
      .o_v_next (v_next),
      .o_hs     (o_hs),
      .o_vs     (o_vs),
      .o_rgb    (vga_rgb)
   );

   assign o_r = vga_rgb.r;
   assign o_g = vga_rgb.g;
   assign o_b = vga_rgb.b;

endmodule

/* src/vga_ram_pkg.sv */
package vga_ram_pkg;

   //////////////////////////////////////////////////
   // 640x480 raster
   localparam int H_ACTIVE = 640;
   localparam int H_FP     = 16;
   localparam int H_SP     = 96;
   localparam int H_BP     = 48;
   localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SP + H_BP;   // 800

   localparam int V_ACTIVE = 480;
   localparam int V_FP     = 11;
   localparam int V_SP     = 2;
   localparam int V_BP     = 31;
   localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SP + V_BP;   // 524

   localparam int CNT_W    = 10;

   //////////////////////////////////////////////////
   // Framebuffer, 180x180 at 2 bpp
   localparam int FB_SIZE     = 180;
   localparam int FB_ADDR_W   = 15;
   localparam int BANK_ADDR_W = 11;
   localparam int N_BANKS     = 16;

   // Bit period counter in the UART
   localparam int BAUD_W = 16;

   typedef logic [1:0] pix_code_t;

   typedef struct packed {
      logic       cont;    // Step to next pixel
      logic [4:0] rsvd;
      pix_code_t  pix;
   } rx_cmd_t;

   typedef union packed {
      logic [7:0] raw;
      rx_cmd_t    cmd;
   } rx_byte_u;

   typedef struct packed {
      logic [1:0] r;
      logic [1:0] g;
      logic [1:0] b;
   } rgb_t;

   // Palette
   localparam rgb_t RGB_BLACK  = '{r: 2'b00, g: 2'b00, b: 2'b00};
   localparam rgb_t RGB_RED    = '{r: 2'b11, g: 2'b00, b: 2'b00};
   localparam rgb_t RGB_YELLOW = '{r: 2'b11, g: 2'b11, b: 2'b00};
   localparam rgb_t RGB_GREEN  = '{r: 2'b00, g: 2'b11, b: 2'b00};

endpackage

/* src/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing (
   input  logic                            pll_clk,
   input  logic                            i_nrst,
   input  vga_ram_pkg::rgb_t               i_rgb,
   output logic [vga_ram_pkg::CNT_W-1:0]   o_h_next,
   output logic [vga_ram_pkg::CNT_W-1:0]   o_v_next,
   output logic                            o_hs,
   output logic                            o_vs,
   output vga_ram_pkg::rgb_t               o_rgb
);

   logic [vga_ram_pkg::CNT_W-1:0] h;
   logic [vga_ram_pkg::CNT_W-1:0] v;
   logic                          h_last;
   logic                          v_last;
   logic                          hs_on;
   logic                          vs_on;
   logic                          active;

   assign h_last = (h == vga_ram_pkg::CNT_W'(vga_ram_pkg::H_TOTAL - 1));
   assign v_last = (v == vga_ram_pkg::CNT_W'(vga_ram_pkg::V_TOTAL - 1));

   //////////////////////////////////////////////////
   // Next raster position, fed to the frame store
   always_comb begin
      o_h_next = h + 1'b1;
      o_v_next = v;
      if (h_last) begin
         o_h_next = '0;
         o_v_next = v_last ? '0 : v + 1'b1;
      end
   end

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         h <= '0;
         v <= '0;
      end else begin
         h <= o_h_next;
         v <= o_v_next;
      end
   end

   // Sync windows, both active low
   assign hs_on = (h >= vga_ram_pkg::H_ACTIVE + vga_ram_pkg::H_FP) &&
                  (h <  vga_ram_pkg::H_ACTIVE + vga_ram_pkg::H_FP + vga_ram_pkg::H_SP);
   assign vs_on = (v >= vga_ram_pkg::V_ACTIVE + vga_ram_pkg::V_FP) &&
                  (v <  vga_ram_pkg::V_ACTIVE + vga_ram_pkg::V_FP + vga_ram_pkg::V_SP);
   assign active = (h < vga_ram_pkg::H_ACTIVE) && (v < vga_ram_pkg::V_ACTIVE);

   //////////////////////////////////////////////////
   // Output registers
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_hs  <= 1'b1;
         o_vs  <= 1'b1;
         o_rgb <= vga_ram_pkg::RGB_BLACK;
      end else begin
         o_hs  <= !hs_on;
         o_vs  <= !vs_on;
         o_rgb <= active ? i_rgb : vga_ram_pkg::RGB_BLACK;   // Blank porches
      end
   end

endmodule

/* testbench/tb_vga_ram.sv */
`timescale 1ns/10ps

module tb_vga_ram;

   localparam int RESET_CYCLES = 10;
   localparam int FB_PIX       = vga_ram_pkg::FB_SIZE * vga_ram_pkg::FB_SIZE;
   localparam int HS_START     = vga_ram_pkg::H_ACTIVE + vga_ram_pkg::H_FP;
   localparam int HS_END       = HS_START + vga_ram_pkg::H_SP;
   localparam int VS_START     = vga_ram_pkg::V_ACTIVE + vga_ram_pkg::V_FP;
   localparam int VS_END       = VS_START + vga_ram_pkg::V_SP;

   logic       pll_clk;
   logic       i_nrst;
   logic       i_rx;
   logic       o_hs;
   logic       o_vs;
   logic [1:0] o_r;
   logic [1:0] o_g;
   logic [1:0] o_b;

   logic [31:0] tdata [0:63];      // Raw words of the data file
   logic [1:0]  model [0:FB_PIX-1];
   logic [7:0]  file_rgb [0:FB_PIX-1];   // 8'hFF marks no check

   int          bit_period   = 0;
   int          wd_cycles    = 0;
   int          errors       = 0;
   int          file_hits    = 0;
   logic        sending_done = 1'b0;
   logic        frame_done   = 1'b0;
   logic [15:0] lfsr         = 16'd7217;

   vga_ram dut_i (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_rx),
      .o_hs    (o_hs),
      .o_vs    (o_vs),
      .o_r     (o_r),
      .o_g     (o_g),
      .o_b     (o_b)
   );

   initial begin
      pll_clk = 1'b0;
      forever #4 pll_clk = ~pll_clk;
   end

   //////////////////////////////////////////////////
   // Helpers
   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // Taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // Colour table of the display
   function automatic logic [5:0] palette_rgb(input logic [1:0] code);
      case (code)
         2'b00:   return 6'b000000;
         2'b01:   return 6'b110000;
         2'b10:   return 6'b111100;
         2'b11:   return 6'b001100;
         default: return 6'b000000;
      endcase
   endfunction

   task automatic idle_gap(input logic rnd);
      int n;
      int k;
      n = 0;
      if (rnd) begin
         for (k = 0; k < 3; k++) begin
            lfsr = lfsr_next(lfsr);   // One step per bit
            n    = (n << 1) | lfsr[0];
         end
      end else begin
         n = 2 * bit_period;
      end
      repeat (n) @(negedge pll_clk);
   endtask

   // 8N1, LSB first
   task automatic send_byte(input logic [7:0] b);
      int i;
      i_rx = 1'b0;
      repeat (bit_period) @(negedge pll_clk);
      for (i = 0; i < 8; i++) begin
         i_rx = b[i];
         repeat (bit_period) @(negedge pll_clk);
      end
      i_rx = 1'b1;
      repeat (bit_period) @(negedge pll_clk);
   endtask

   //////////////////////////////////////////////////
   // Stimulus and final verdict
   initial begin : stimulus
      int          n_entries;
      int          n_checks;
      int          total;
      int          e;
      int          k;
      int          wptr;
      logic [31:0] w;

      i_nrst = 1'b0;
      i_rx   = 1'b1;
      $readmemh("testbench/vga_ram_testdata.txt", tdata);
      for (k = 0; k < FB_PIX; k++) begin
         file_rgb[k] = 8'hFF;
      end
      bit_period = tdata[0];
      n_entries  = tdata[1];
      total      = 0;
      for (e = 0; e < n_entries; e++) begin
         total += tdata[2 + e][31:16];
      end
      n_checks = tdata[2 + n_entries];
      for (e = 0; e < n_checks; e++) begin
         w = tdata[3 + n_entries + e];
         file_rgb[w[31:8]] = w[7:0];
      end
      wd_cycles = total * 10 * bit_period * 2 +
                  3 * vga_ram_pkg::H_TOTAL * vga_ram_pkg::V_TOTAL + RESET_CYCLES;

      repeat (RESET_CYCLES) @(negedge pll_clk);
      i_nrst = 1'b1;
      repeat (4 * bit_period) @(negedge pll_clk);

      wptr = 0;
      for (e = 0; e < n_entries; e++) begin
         w = tdata[2 + e];
         for (k = 0; k < w[31:16]; k++) begin
            idle_gap(w[8]);
            send_byte(w[7:0]);
            model[wptr] = w[1:0];
            wptr = w[7] ? wptr + 1 : 0;   // Continue flag steps
         end
      end
      repeat (4 * bit_period) @(negedge pll_clk);   // Last write settles
      sending_done = 1'b1;

      wait (frame_done === 1'b1);
      check_val("file_checks_seen", n_checks, file_hits);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("TEST RESULT: FAIL");
         $fatal(1, "Errors were found");
      end
   end

   //////////////////////////////////////////////////
   // Raster tracking and output checks
   initial begin : raster_monitor
      int         h;
      int         v;
      int         a;
      logic       vs_prev;
      logic       in_frame;
      logic [5:0] rgb_s;
      logic [5:0] exp_rgb;

      in_frame = 1'b0;
      repeat (2) @(negedge pll_clk);
      check_val("reset_hs", 1, o_hs);
      check_val("reset_vs", 1, o_vs);
      check_val("reset_black", 0, {o_r, o_g, o_b});

      wait (i_nrst === 1'b1);
      @(negedge pll_clk);
      while (o_hs !== 1'b0) begin        // Up to the first hsync
         check_val("startup_vs", 1, o_vs);
         check_val("startup_black", 0, {o_r, o_g, o_b});
         @(negedge pll_clk);
      end

      vs_prev = o_vs;
      @(negedge pll_clk);
      while (!(vs_prev === 1'b1 && o_vs === 1'b0)) begin
         vs_prev = o_vs;
         @(negedge pll_clk);
      end
      h = 0;
      v = VS_START;

      while (frame_done !== 1'b1) begin
         if (h == 0 && v == 0 && sending_done) begin
            in_frame = 1'b1;
         end
         check_val("hsync", !(h >= HS_START && h < HS_END), o_hs);
         check_val("vsync", !(v >= VS_START && v < VS_END), o_vs);
         if (in_frame) begin
            rgb_s   = {o_r, o_g, o_b};
            exp_rgb = 6'b000000;
            if (h < vga_ram_pkg::FB_SIZE && v < vga_ram_pkg::FB_SIZE) begin
               a       = v * vga_ram_pkg::FB_SIZE + h;
               exp_rgb = palette_rgb(model[a]);
               if (file_rgb[a] !== 8'hFF) begin
                  check_val($sformatf("file_pixel_%0d", a), file_rgb[a], rgb_s);
                  file_hits++;
               end
            end
            check_val($sformatf("pixel_h%0d_v%0d", h, v), exp_rgb, rgb_s);
            if (h == vga_ram_pkg::H_TOTAL - 1 && v == vga_ram_pkg::V_TOTAL - 1) begin
               frame_done = 1'b1;
            end
         end
         h++;
         if (h == vga_ram_pkg::H_TOTAL) begin
            h = 0;
            v = (v == vga_ram_pkg::V_TOTAL - 1) ? 0 : v + 1;
         end
         @(negedge pll_clk);
      end
   end

   initial begin : watchdog
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge pll_clk);
      $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Watchdog expired");
   end

endmodule

/* testbench/vga_ram_testdata.txt */
// Word 0 bit period in cycles, word 1 number of byte entries
// Entry {count[31:16], rand_gap[8], byte[7:0]}, then check count, check {addr[31:8], rgb[7:0]}
00000008
0000000A
// Calibration byte, red at pixel 0
00010081
07FE0182
00010183
00010181
13880180
1E610181
23290183
217C0182
// Last pixel with continue clear, then pixel 0 overwritten
00010101
00010083
// Pixel checks
0000000E
0000000C
0000013C
0007FE3C
0007FF0C
00080030
00080100
001B8800
001B8930
0039E930
0039EA0C
005D120C
005D133C
007E8E3C
007E8F30
